/* common/mcbsp_pkg.sv */
package mcbsp_pkg;

  //////////////////////////////////////////////////
  // serial word framing

  localparam int word_w    = 32;
  localparam int bit_cnt_w = 5;   // one count per bit of a word

  typedef logic [word_w-1:0] word_t;

  //////////////////////////////////////////////////
  // loopback block

  localparam int loop_depth  = 128;  // words stored per sync
  localparam int loop_addr_w = 7;

  typedef logic [loop_addr_w-1:0] loop_addr_t;

endpackage

/* common/dsp_cmd_pkg.sv */
package dsp_cmd_pkg;

  //////////////////////////////////////////////////
  // packet headers sent by the DSP

  localparam mcbsp_pkg::word_t hdr_mode = 32'h2222_dddd;  // work mode packet
  localparam mcbsp_pkg::word_t hdr_pa   = 32'h1111_eeee;  // power amplifier control
  localparam mcbsp_pkg::word_t hdr_sync = 32'h6666_9999;  // loopback sync

  // work mode
  typedef logic [3:0] work_mode_t;

  localparam work_mode_t mode_loop = 4'd1;

  //////////////////////////////////////////////////
  // decoder to executer opcodes

  typedef enum logic [1:0] {
    op_mode,
    op_pa,
    op_sync,
    op_data
  } cmd_op_e;

  typedef enum logic [1:0] {
    idle,
    mode_arg,
    pa_cfg,
    pa_para
  } dec_state_e;

  // wishbone write sequencer
  typedef enum logic [1:0] {
    wb_idle,
    wb_cfg,
    wb_gap,     // one idle cycle between the two writes
    wb_para
  } wb_state_e;

  // hardware port registers
  localparam logic [7:0] port_adr_cfg  = 8'h00;
  localparam logic [7:0] port_adr_para = 8'h01;

endpackage

/* verilog/mcbsp_frame_rx.sv */
`timescale 1ns/10ps

module mcbsp_frame_rx (
  input  logic             mcbsp_slaver_clkx,
  input  logic             mcbsp_rst_in,
  input  logic             mcbsp_slaver_mosi,
  input  logic             mcbsp_slaver_fsx,
  output mcbsp_pkg::word_t rx_word,
  output logic             rx_valid
);

  logic                            rx_active;  // bits of the frame still coming
  logic [mcbsp_pkg::bit_cnt_w-1:0] bit_cnt;
  mcbsp_pkg::word_t                shift_q;

  //////////////////////////////////////////////////
  // frame control, armed by fsx

  always_ff @(posedge mcbsp_slaver_clkx or posedge mcbsp_rst_in) begin
    if (mcbsp_rst_in) begin
      rx_active <= 1'b0;
      bit_cnt   <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (mcbsp_slaver_fsx) begin       // sync restarts the word
        rx_active <= 1'b1;
        bit_cnt   <= '0;
      end else if (rx_active) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (&bit_cnt) begin             // 32nd bit taken
          rx_active <= 1'b0;
          rx_valid  <= 1'b1;
        end
      end
    end
  end

  // msb arrives first
  always_ff @(posedge mcbsp_slaver_clkx) begin
    if (rx_active && !mcbsp_slaver_fsx) begin
      shift_q <= {shift_q[mcbsp_pkg::word_w-2:0], mcbsp_slaver_mosi};
    end
  end

  // word stays put until the next frame starts shifting
  assign rx_word = shift_q;

endmodule

/* cmd/dsp_cmd_decode.sv */
`timescale 1ns/10ps

module dsp_cmd_decode (
  input  logic                 mcbsp_slaver_clkx,
  input  logic                 mcbsp_rst_in,
  input  mcbsp_pkg::word_t     rx_word,
  input  logic                 rx_valid,
  output logic                 cmd_valid,
  output dsp_cmd_pkg::cmd_op_e cmd_op,
  output mcbsp_pkg::word_t     cmd_arg0,
  output mcbsp_pkg::word_t     cmd_arg1
);

  dsp_cmd_pkg::dec_state_e state;

  //////////////////////////////////////////////////
  // packet parser

  always_ff @(posedge mcbsp_slaver_clkx or posedge mcbsp_rst_in) begin
    if (mcbsp_rst_in) begin
      state     <= dsp_cmd_pkg::idle;
      cmd_valid <= 1'b0;
      cmd_op    <= dsp_cmd_pkg::op_data;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          dsp_cmd_pkg::idle: begin
            if (rx_word == dsp_cmd_pkg::hdr_mode) begin
              state <= dsp_cmd_pkg::mode_arg;
            end else if (rx_word == dsp_cmd_pkg::hdr_pa) begin
              state <= dsp_cmd_pkg::pa_cfg;
            end else if (rx_word == dsp_cmd_pkg::hdr_sync) begin
              cmd_valid <= 1'b1;
              cmd_op    <= dsp_cmd_pkg::op_sync;
            end else begin
              cmd_valid <= 1'b1;             // plain data word
              cmd_op    <= dsp_cmd_pkg::op_data;
            end
          end
          dsp_cmd_pkg::mode_arg: begin
            cmd_valid <= 1'b1;
            cmd_op    <= dsp_cmd_pkg::op_mode;
            state     <= dsp_cmd_pkg::idle;
          end
          dsp_cmd_pkg::pa_cfg: begin
            state <= dsp_cmd_pkg::pa_para;     // config held in arg0
          end
          dsp_cmd_pkg::pa_para: begin
            cmd_valid <= 1'b1;
            cmd_op    <= dsp_cmd_pkg::op_pa;
            state     <= dsp_cmd_pkg::idle;
          end
          default: state <= dsp_cmd_pkg::idle;
        endcase
      end
    end
  end

  // arguments
  // arg1 only takes the parameter word, arg0 keeps the config across it
  always_ff @(posedge mcbsp_slaver_clkx) begin
    if (rx_valid) begin
      if (state == dsp_cmd_pkg::pa_para) begin
        cmd_arg1 <= rx_word;
      end else begin
        cmd_arg0 <= rx_word;
      end
    end
  end

endmodule

/* cmd/dsp_cmd_execute.sv */
`timescale 1ns/10ps

module dsp_cmd_execute (
  input  logic                    mcbsp_slaver_clkx,
  input  logic                    mcbsp_rst_in,
  input  logic                    cmd_valid,
  input  dsp_cmd_pkg::cmd_op_e    cmd_op,
  input  mcbsp_pkg::word_t        cmd_arg0,
  input  mcbsp_pkg::word_t        cmd_arg1,
  input  logic                    wb_ack,
  input  logic                    tx_busy,
  output dsp_cmd_pkg::work_mode_t work_mode,
  output logic                    work_mode_vld,
  output logic                    dsp_ctr_uart_en,
  output logic [63:0]             dsp_ctr_uart_data,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output logic [7:0]              wb_adr,
  output mcbsp_pkg::word_t        wb_dat,
  output logic                    loop_wr_en,
  output mcbsp_pkg::loop_addr_t   loop_wr_addr,
  output mcbsp_pkg::word_t        loop_wr_data,
  output logic                    loop_start
);

  dsp_cmd_pkg::wb_state_e wb_state;
  logic                   cap_on;     // storing loopback words
  mcbsp_pkg::loop_addr_t  cap_addr;
  logic                   pa_take;
  logic                   sync_take;
  logic                   data_take;

  // pa packet dropped while the port writes are still running
  assign pa_take   = cmd_valid && (cmd_op == dsp_cmd_pkg::op_pa) &&
                     (wb_state == dsp_cmd_pkg::wb_idle);
  assign sync_take = cmd_valid && (cmd_op == dsp_cmd_pkg::op_sync) &&
                     (work_mode == dsp_cmd_pkg::mode_loop) && !tx_busy && !cap_on;
  assign data_take = cmd_valid && (cmd_op == dsp_cmd_pkg::op_data) && cap_on;

  //////////////////////////////////////////////////
  // work mode and control word

  always_ff @(posedge mcbsp_slaver_clkx or posedge mcbsp_rst_in) begin
    if (mcbsp_rst_in) begin
      work_mode         <= '0;
      work_mode_vld     <= 1'b0;
      dsp_ctr_uart_en   <= 1'b0;
      dsp_ctr_uart_data <= '0;
    end else begin
      work_mode_vld   <= 1'b0;
      dsp_ctr_uart_en <= pa_take;
      if (cmd_valid && (cmd_op == dsp_cmd_pkg::op_mode)) begin
        work_mode     <= cmd_arg0[3:0];
        work_mode_vld <= 1'b1;
      end
      if (pa_take) dsp_ctr_uart_data <= {cmd_arg0, cmd_arg1};  // config high
    end
  end

  //////////////////////////////////////////////////
  // wishbone writes to the hardware port

  always_ff @(posedge mcbsp_slaver_clkx or posedge mcbsp_rst_in) begin
    if (mcbsp_rst_in) begin
      wb_state <= dsp_cmd_pkg::wb_idle;
    end else begin
      case (wb_state)
        dsp_cmd_pkg::wb_idle: if (pa_take) wb_state <= dsp_cmd_pkg::wb_cfg;
        dsp_cmd_pkg::wb_cfg:  if (wb_ack) wb_state <= dsp_cmd_pkg::wb_gap;
        dsp_cmd_pkg::wb_gap:  wb_state <= dsp_cmd_pkg::wb_para;
        dsp_cmd_pkg::wb_para: if (wb_ack) wb_state <= dsp_cmd_pkg::wb_idle;
        default:              wb_state <= dsp_cmd_pkg::wb_idle;
      endcase
    end
  end

  // bus held steady for the whole write state
  assign wb_cyc = (wb_state == dsp_cmd_pkg::wb_cfg) || (wb_state == dsp_cmd_pkg::wb_para);
  assign wb_stb = wb_cyc;
  assign wb_we  = wb_cyc;  // write only master
  assign wb_adr = (wb_state == dsp_cmd_pkg::wb_para) ? dsp_cmd_pkg::port_adr_para
                                                     : dsp_cmd_pkg::port_adr_cfg;
  assign wb_dat = (wb_state == dsp_cmd_pkg::wb_para) ? dsp_ctr_uart_data[31:0]
                                                     : dsp_ctr_uart_data[63:32];

  //////////////////////////////////////////////////
  // loopback capture

  always_ff @(posedge mcbsp_slaver_clkx or posedge mcbsp_rst_in) begin
    if (mcbsp_rst_in) begin
      cap_on     <= 1'b0;
      cap_addr   <= '0;
      loop_wr_en <= 1'b0;
      loop_start <= 1'b0;
    end else begin
      loop_wr_en <= data_take;
      loop_start <= loop_wr_en &&
                    (loop_wr_addr == mcbsp_pkg::loop_addr_t'(mcbsp_pkg::loop_depth - 1));
      if (sync_take) begin
        cap_on   <= 1'b1;
        cap_addr <= '0;
      end else if (data_take) begin
        cap_addr <= cap_addr + 1'b1;
        if (cap_addr == mcbsp_pkg::loop_addr_t'(mcbsp_pkg::loop_depth - 1)) begin
          cap_on <= 1'b0;  // block full
        end
      end
    end
  end

  always_ff @(posedge mcbsp_slaver_clkx) begin
    if (data_take) begin
      loop_wr_addr <= cap_addr;
      loop_wr_data <= cmd_arg0;
    end
  end

endmodule

/* loop/loop_frame_tx.sv */
`timescale 1ns/10ps

module loop_frame_tx (
  input  logic                  mcbsp_slaver_clkx,
  input  logic                  mcbsp_rst_in,
  input  logic                  loop_wr_en,
  input  mcbsp_pkg::loop_addr_t loop_wr_addr,
  input  mcbsp_pkg::word_t      loop_wr_data,
  input  logic                  loop_start,
  output logic                  tx_busy,
  output logic                  mcbsp_master_fsr,
  output logic                  mcbsp_master_miso
);

  mcbsp_pkg::word_t      loop_mem [mcbsp_pkg::loop_depth];
  mcbsp_pkg::word_t      rd_word;
  mcbsp_pkg::word_t      shift_q;
  mcbsp_pkg::loop_addr_t rd_addr;
  logic [5:0]            frm_cnt;    // 0 is the fsr slot, 1..32 the bits
  logic                  last_word;  // final word is on the line

  //////////////////////////////////////////////////
  // loopback buffer

  always_ff @(posedge mcbsp_slaver_clkx) begin
    if (loop_wr_en) loop_mem[loop_wr_addr] <= loop_wr_data;
  end

  // registered read, ready by the fsr cycle
  always_ff @(posedge mcbsp_slaver_clkx) begin
    rd_word <= loop_mem[rd_addr];
  end

  //////////////////////////////////////////////////
  // word framing, 33 cycles per word

  always_ff @(posedge mcbsp_slaver_clkx or posedge mcbsp_rst_in) begin
    if (mcbsp_rst_in) begin
      tx_busy          <= 1'b0;
      rd_addr          <= '0;
      frm_cnt          <= '0;
      last_word        <= 1'b0;
      mcbsp_master_fsr <= 1'b0;
    end else begin
      mcbsp_master_fsr <= tx_busy && (frm_cnt == '0);
      if (loop_start) begin
        tx_busy   <= 1'b1;
        rd_addr   <= '0;
        frm_cnt   <= '0;
        last_word <= 1'b0;
      end else if (tx_busy) begin
        if (frm_cnt == 6'(mcbsp_pkg::word_w)) begin
          frm_cnt <= '0;
          if (last_word) begin
            tx_busy   <= 1'b0;  // all words sent
            last_word <= 1'b0;
          end
        end else begin
          frm_cnt <= frm_cnt + 1'b1;
        end
        if (frm_cnt == 6'd1) begin  // word loaded, move to the next
          rd_addr   <= rd_addr + 1'b1;
          last_word <= (rd_addr == mcbsp_pkg::loop_addr_t'(mcbsp_pkg::loop_depth - 1));
        end
      end
    end
  end

  // serializer, msb first
  always_ff @(posedge mcbsp_slaver_clkx or posedge mcbsp_rst_in) begin
    if (mcbsp_rst_in) begin
      shift_q <= '0;
    end else if (tx_busy && (frm_cnt == 6'd1)) begin
      shift_q <= rd_word;
    end else if (tx_busy) begin
      shift_q <= shift_q << 1;
    end else begin
      shift_q <= '0;  // line idles low
    end
  end

  assign mcbsp_master_miso = shift_q[mcbsp_pkg::word_w-1];

endmodule

/* verilog/mcbsp_dsp_cmd_top.sv */
`timescale 1ns/10ps

module mcbsp_dsp_cmd_top (
  input  logic                    mcbsp_slaver_clkx,
  input  logic                    mcbsp_rst_in,
  input  logic                    mcbsp_slaver_mosi,
  input  logic                    mcbsp_slaver_fsx,
  input  logic                    wb_ack,
  output logic                    mcbsp_master_fsr,
  output logic                    mcbsp_master_miso,
  output dsp_cmd_pkg::work_mode_t work_mode,
  output logic                    work_mode_vld,
  output logic                    dsp_ctr_uart_en,
  output logic [63:0]             dsp_ctr_uart_data,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output logic [7:0]              wb_adr,
  output mcbsp_pkg::word_t        wb_dat
);

  // receiver to decoder
  mcbsp_pkg::word_t      rx_word;
  logic                  rx_valid;

  // decoder to executer
  logic                  cmd_valid;
  dsp_cmd_pkg::cmd_op_e  cmd_op;
  mcbsp_pkg::word_t      cmd_arg0;
  mcbsp_pkg::word_t      cmd_arg1;

  // loopback path
  logic                  loop_wr_en;
  mcbsp_pkg::loop_addr_t loop_wr_addr;
  mcbsp_pkg::word_t      loop_wr_data;
  logic                  loop_start;
  logic                  tx_busy;

  mcbsp_frame_rx u_frame_rx (
    .mcbsp_slaver_clkx (mcbsp_slaver_clkx),
    .mcbsp_rst_in      (mcbsp_rst_in),
    .mcbsp_slaver_mosi (mcbsp_slaver_mosi),
    .mcbsp_slaver_fsx  (mcbsp_slaver_fsx),
    .rx_word           (rx_word),
    .rx_valid          (rx_valid)
  );

  dsp_cmd_decode u_cmd_decode (
    .mcbsp_slaver_clkx (mcbsp_slaver_clkx),
    .mcbsp_rst_in      (mcbsp_rst_in),
    .rx_word           (rx_word),
    .rx_valid          (rx_valid),
    .cmd_valid         (cmd_valid),
    .cmd_op            (cmd_op),
    .cmd_arg0          (cmd_arg0),
    .cmd_arg1          (cmd_arg1)
  );

  dsp_cmd_execute u_cmd_execute (
    .mcbsp_slaver_clkx (mcbsp_slaver_clkx),
    .mcbsp_rst_in      (mcbsp_rst_in),
    .cmd_valid         (cmd_valid),
    .cmd_op            (cmd_op),
    .cmd_arg0          (cmd_arg0),
    .cmd_arg1          (cmd_arg1),
    .wb_ack            (wb_ack),
    .tx_busy           (tx_busy),
    .work_mode         (work_mode),
    .work_mode_vld     (work_mode_vld),
    .dsp_ctr_uart_en   (dsp_ctr_uart_en),
    .dsp_ctr_uart_data (dsp_ctr_uart_data),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_adr            (wb_adr),
    .wb_dat            (wb_dat),
    .loop_wr_en        (loop_wr_en),
    .loop_wr_addr      (loop_wr_addr),
    .loop_wr_data      (loop_wr_data),
    .loop_start        (loop_start)
  );

  loop_frame_tx u_loop_tx (
    .mcbsp_slaver_clkx (mcbsp_slaver_clkx),
    .mcbsp_rst_in      (mcbsp_rst_in),
    .loop_wr_en        (loop_wr_en),
    .loop_wr_addr      (loop_wr_addr),
    .loop_wr_data      (loop_wr_data),
    .loop_start        (loop_start),
    .tx_busy           (tx_busy),
    .mcbsp_master_fsr  (mcbsp_master_fsr),
    .mcbsp_master_miso (mcbsp_master_miso)
  );

endmodule

/* dv/tb_mcbsp_tasks.svh */
//////////////////////////////////////////////////
// drivers and helpers

// one fsx framed word, msb first
task automatic send_word(input mcbsp_pkg::word_t w);
  int i;
  @(negedge mcbsp_slaver_clkx);
  mcbsp_slaver_fsx  = 1'b1;
  mcbsp_slaver_mosi = 1'b0;
  for (i = mcbsp_pkg::word_w - 1; i >= 0; i--) begin
    @(negedge mcbsp_slaver_clkx);
    mcbsp_slaver_fsx  = 1'b0;
    mcbsp_slaver_mosi = w[i];
  end
endtask

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// headers are redrawn, they never travel as data
task automatic draw_data_word(output mcbsp_pkg::word_t w);
  int i;
  do begin
    w = '0;
    for (i = 0; i < mcbsp_pkg::word_w; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[mcbsp_pkg::word_w-2:0], lfsr_state[0]};
    end
  end while (w == dsp_cmd_pkg::hdr_mode || w == dsp_cmd_pkg::hdr_pa ||
             w == dsp_cmd_pkg::hdr_sync);
endtask

task automatic check_equal(input string test, input logic [63:0] expected,
                           input logic [63:0] actual);
  if (expected !== actual) begin
    error_count++;
    $display("Error in %s: expected %0h, actual %0h", test, expected, actual);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  end
endtask

task automatic report_stall(input string test, input string what);
  $display("%s: %s", test, what);
  $display("Some tests failed");
  $fatal(1, "stopped, the DUT did not respond");
endtask

// mode packet, vld expected on the third falling edge after the last bit
task automatic select_mode(input string test, input dsp_cmd_pkg::work_mode_t mode);
  int lat;
  send_word(dsp_cmd_pkg::hdr_mode);
  send_word({28'h5a5a_5a5, mode});  // upper bits unused
  lat = 0;
  do begin
    @(negedge mcbsp_slaver_clkx);
    lat++;
  end while (!work_mode_vld && lat < 20);
  if (!work_mode_vld) report_stall(test, "work_mode_vld did not pulse after a mode packet");
  check_equal({test, " mode latency"}, 64'(3), 64'(lat));  // rx_valid cycle plus two
  check_equal({test, " work_mode"}, 64'(mode), 64'(work_mode));
endtask

//////////////////////////////////////////////////
// directed tests

task automatic check_reset_state();
  check_equal("reset work_mode", 64'(0), 64'(work_mode));
  check_equal("reset work_mode_vld", 64'(0), 64'(work_mode_vld));
  check_equal("reset wb_cyc", 64'(0), 64'(wb_cyc));
  check_equal("reset dsp_ctr_uart_en", 64'(0), 64'(dsp_ctr_uart_en));
  check_equal("reset fsr", 64'(0), 64'(mcbsp_master_fsr));
endtask

task automatic mode_packet();
  int base;
  base = vld_pulses;
  select_mode("mode_packet", 4'd5);
  repeat (10) @(negedge mcbsp_slaver_clkx);
  check_equal("mode_packet vld pulses", 64'(1), 64'(vld_pulses - base));
  check_equal("mode_packet work_mode", 64'(5), 64'(work_mode));
endtask

task automatic control_packet();
  mcbsp_pkg::word_t cfg;
  mcbsp_pkg::word_t para;
  int               en_base;
  int               log_base;
  int               glitch_base;
  int               lat;
  int               n;
  cfg         = 32'h0c3a_5a01;
  para        = 32'h8000_7f21;
  ack_delay   = 3;
  en_base     = en_pulses;
  log_base    = log_adr.size();
  glitch_base = bus_glitches;
  send_word(dsp_cmd_pkg::hdr_pa);
  send_word(cfg);
  send_word(para);
  lat = 0;
  do begin
    @(negedge mcbsp_slaver_clkx);
    lat++;
  end while (!dsp_ctr_uart_en && lat < 20);
  if (!dsp_ctr_uart_en) report_stall("control_packet", "dsp_ctr_uart_en did not pulse");
  check_equal("control_packet en latency", 64'(3), 64'(lat));
  check_equal("control_packet uart data", {cfg, para}, dsp_ctr_uart_data);
  check_equal("control_packet cyc with en", 64'(1), 64'(wb_cyc));
  n = 0;
  while (log_adr.size() < log_base + 2 && n < 40) begin
    @(negedge mcbsp_slaver_clkx);
    n++;
  end
  if (log_adr.size() < log_base + 2) report_stall("control_packet", "two port writes not seen");
  repeat (4) @(negedge mcbsp_slaver_clkx);
  check_equal("control_packet en pulses", 64'(1), 64'(en_pulses - en_base));
  check_equal("control_packet write count", 64'(2), 64'(log_adr.size() - log_base));
  check_equal("control_packet bus held", 64'(0), 64'(bus_glitches - glitch_base));
  check_equal("control_packet cfg adr", 64'(dsp_cmd_pkg::port_adr_cfg), 64'(log_adr[log_base]));
  check_equal("control_packet cfg dat", 64'(cfg), 64'(log_dat[log_base]));
  check_equal("control_packet para adr", 64'(dsp_cmd_pkg::port_adr_para),
              64'(log_adr[log_base+1]));
  check_equal("control_packet para dat", 64'(para), 64'(log_dat[log_base+1]));
  check_equal("control_packet cyc idle", 64'(0), 64'(wb_cyc));
endtask

// sync outside loopback mode must not start a transfer even after a full block
task automatic sync_ignored();
  mcbsp_pkg::word_t w;
  int               fsr_base;
  int               i;
  select_mode("sync_ignored", 4'd5);
  fsr_base = fsr_pulses;
  send_word(dsp_cmd_pkg::hdr_sync);
  for (i = 0; i < mcbsp_pkg::loop_depth; i++) begin
    draw_data_word(w);
    send_word(w);
  end
  repeat (500) @(negedge mcbsp_slaver_clkx);
  check_equal("sync_ignored fsr pulses", 64'(0), 64'(fsr_pulses - fsr_base));
endtask

task automatic loopback_block();
  mcbsp_pkg::word_t sent[$];
  mcbsp_pkg::word_t w;
  int               base;
  int               n;
  int               i;
  select_mode("loopback", dsp_cmd_pkg::mode_loop);
  base = echo_words.size();
  send_word(dsp_cmd_pkg::hdr_sync);
  for (i = 0; i < mcbsp_pkg::loop_depth; i++) begin
    draw_data_word(w);
    sent.push_back(w);
    send_word(w);
  end
  n = 0;
  while (echo_words.size() < base + mcbsp_pkg::loop_depth && n < 128 * 33 + 100) begin
    @(negedge mcbsp_slaver_clkx);
    n++;
  end
  if (echo_words.size() < base + mcbsp_pkg::loop_depth) begin
    report_stall("loopback", "fewer than 128 words came back on miso");
  end
  repeat (66) @(negedge mcbsp_slaver_clkx);  // room for a stray extra word
  check_equal("loopback word count", 64'(mcbsp_pkg::loop_depth),
              64'(echo_words.size() - base));
  for (i = 0; i < mcbsp_pkg::loop_depth; i++) begin
    check_equal($sformatf("loopback word %0d", i), 64'(sent[i]), 64'(echo_words[base+i]));
  end
endtask

/* dv/tb_mcbsp_dsp_cmd.sv */
`timescale 1ns/10ps

module tb_mcbsp_dsp_cmd;

  localparam int clk_half = 10;  // 20 ns period

  // two 128 word blocks in and one block out plus the short packets take about 13700 cycles
  localparam int timeout_cycles = 20000;

  logic                    mcbsp_slaver_clkx;
  logic                    mcbsp_rst_in;
  logic                    mcbsp_slaver_mosi;
  logic                    mcbsp_slaver_fsx;
  logic                    wb_ack;
  logic                    mcbsp_master_fsr;
  logic                    mcbsp_master_miso;
  dsp_cmd_pkg::work_mode_t work_mode;
  logic                    work_mode_vld;
  logic                    dsp_ctr_uart_en;
  logic [63:0]             dsp_ctr_uart_data;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [7:0]              wb_adr;
  mcbsp_pkg::word_t        wb_dat;

  // monitor and responder state
  mcbsp_pkg::word_t echo_words[$];  // words seen on miso
  logic [7:0]       log_adr[$];
  mcbsp_pkg::word_t log_dat[$];
  int               ack_delay    = 1;
  int               bus_glitches = 0;
  int               vld_pulses   = 0;
  int               en_pulses    = 0;
  int               fsr_pulses   = 0;
  int               cycle_count  = 0;
  int               error_count  = 0;
  logic [31:0]      lfsr_state   = 32'hc219;

  mcbsp_dsp_cmd_top dut_i (
    .mcbsp_slaver_clkx (mcbsp_slaver_clkx),
    .mcbsp_rst_in      (mcbsp_rst_in),
    .mcbsp_slaver_mosi (mcbsp_slaver_mosi),
    .mcbsp_slaver_fsx  (mcbsp_slaver_fsx),
    .wb_ack            (wb_ack),
    .mcbsp_master_fsr  (mcbsp_master_fsr),
    .mcbsp_master_miso (mcbsp_master_miso),
    .work_mode         (work_mode),
    .work_mode_vld     (work_mode_vld),
    .dsp_ctr_uart_en   (dsp_ctr_uart_en),
    .dsp_ctr_uart_data (dsp_ctr_uart_data),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_adr            (wb_adr),
    .wb_dat            (wb_dat)
  );

  `include "tb_mcbsp_tasks.svh"

  initial begin : clock_gen
    mcbsp_slaver_clkx = 1'b0;
    forever #clk_half mcbsp_slaver_clkx = ~mcbsp_slaver_clkx;
  end

  //////////////////////////////////////////////////
  // monitors

  always @(negedge mcbsp_slaver_clkx) begin
    if (work_mode_vld) vld_pulses++;
    if (dsp_ctr_uart_en) en_pulses++;
    if (mcbsp_master_fsr) fsr_pulses++;
  end

  // miso deserializer, fsr then 32 bits msb first
  initial begin : miso_monitor
    mcbsp_pkg::word_t w;
    forever begin
      @(negedge mcbsp_slaver_clkx);
      if (mcbsp_master_fsr) begin
        w = '0;
        repeat (mcbsp_pkg::word_w) begin
          @(negedge mcbsp_slaver_clkx);
          w = {w[mcbsp_pkg::word_w-2:0], mcbsp_master_miso};
        end
        echo_words.push_back(w);
      end
    end
  end

  // wishbone slave, acks after ack_delay cycles and logs each write
  initial begin : wb_responder
    logic [42:0] held;
    int          i;
    wb_ack = 1'b0;
    forever begin
      @(negedge mcbsp_slaver_clkx);
      if (wb_cyc && wb_stb) begin
        held = {3'b111, wb_adr, wb_dat};  // we must stay high too
        for (i = 0; i < ack_delay; i++) begin
          if ({wb_cyc, wb_stb, wb_we, wb_adr, wb_dat} != held) bus_glitches++;
          @(negedge mcbsp_slaver_clkx);
        end
        if ({wb_cyc, wb_stb, wb_we, wb_adr, wb_dat} != held) bus_glitches++;
        wb_ack = 1'b1;
        log_adr.push_back(wb_adr);
        log_dat.push_back(wb_dat);
        @(negedge mcbsp_slaver_clkx);
        wb_ack = 1'b0;
      end
    end
  end

  always @(posedge mcbsp_slaver_clkx) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("Some tests failed");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////////////////////////
  // test sequence

  initial begin : test_sequence
    mcbsp_rst_in      = 1'b1;
    mcbsp_slaver_fsx  = 1'b0;
    mcbsp_slaver_mosi = 1'b0;
    repeat (10) @(negedge mcbsp_slaver_clkx);
    mcbsp_rst_in = 1'b0;
    check_reset_state();
    mode_packet();
    control_packet();
    sync_ignored();
    loopback_block();
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+dv
common/mcbsp_pkg.sv
common/dsp_cmd_pkg.sv
verilog/mcbsp_frame_rx.sv
cmd/dsp_cmd_decode.sv
cmd/dsp_cmd_execute.sv
loop/loop_frame_tx.sv
verilog/mcbsp_dsp_cmd_top.sv
dv/tb_mcbsp_dsp_cmd.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_mcbsp_dsp_cmd -o tb_mcbsp_dsp_cmd
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_mcbsp_dsp_cmd 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
